//--- cpu16.f
cpu16_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
mem_wb_stage.sv
cpu16_top.sv
cpu16_tb.sv

//--- cpu16_pkg.sv
`default_nettype none

package cpu16_pkg;

	// Datapath and register index widths
	localparam int XLEN   = 16;
	localparam int REG_AW = 4;

	// Instruction layout
	// [15:12] opcode, [11:8] rd or imm, [7:4] rs2 or imm, [3:0] rs1
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_SLL  = 4'h5,
		OP_SRL  = 4'h6,
		OP_ADDI = 4'h7,
		OP_LW   = 4'h8,
		OP_SW   = 4'h9,
		OP_BEQ  = 4'hA,
		OP_BNE  = 4'hB,
		OP_HALT = 4'hC
	} opcode_t;

	// Codes D to F do nothing, F is used for flushed slots
	localparam logic [XLEN-1:0] NOP_INSTR = 16'hF000;

	// Same order as the register-register opcodes
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6
	} alu_op_t;

	// Operand source in execute
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_t;

	typedef enum logic {
		WB_ALU  = 1'b0,
		WB_LOAD = 1'b1
	} wb_sel_t;

endpackage

`default_nettype wire

//--- cpu16_tb.sv
`default_nettype none

module cpu16_tb
	import cpu16_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int IMEM_AW      = 8;
	localparam int DMEM_AW      = 8;
	localparam int PROG_LEN     = 60;
	localparam int RESET_CYCLES = 8;
	localparam int HALT_TIMEOUT = 2000;
	localparam int QUIET_CYCLES = 12;

	logic               clk;
	logic               rst;
	logic               imem_load_en;
	logic [IMEM_AW-1:0] imem_load_addr;
	logic [XLEN-1:0]    imem_load_data;
	logic               retire_valid;
	logic [REG_AW-1:0]  retire_rd;
	logic [XLEN-1:0]    retire_data;
	logic               store_valid;
	logic [DMEM_AW-1:0] store_addr;
	logic [XLEN-1:0]    store_data;
	logic               halted;

	integer seed;
	int     mismatch_count;
	int     other_errors;
	int     retire_count;
	int     store_count;
	int     cycles;

	logic [XLEN-1:0]    prog [PROG_LEN+1];
	logic [XLEN-1:0]    model_regs [2**REG_AW];
	logic [XLEN-1:0]    model_mem [2**DMEM_AW];

	// Expected events in program order
	logic [REG_AW-1:0]  exp_rd_q [$];
	logic [XLEN-1:0]    exp_data_q [$];
	logic [DMEM_AW-1:0] exp_saddr_q [$];
	logic [XLEN-1:0]    exp_sdata_q [$];
	logic [REG_AW-1:0]  exp_rd;
	logic [XLEN-1:0]    exp_data;
	logic [DMEM_AW-1:0] exp_saddr;
	logic [XLEN-1:0]    exp_sdata;

	cpu16_top #(
		.IMEM_AW(IMEM_AW),
		.DMEM_AW(DMEM_AW)
	) cpu16_top_inst (
		.clk(clk),
		.rst(rst),
		.imem_load_en(imem_load_en),
		.imem_load_addr(imem_load_addr),
		.imem_load_data(imem_load_data),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_data(retire_data),
		.store_valid(store_valid),
		.store_addr(store_addr),
		.store_data(store_data),
		.halted(halted)
	);

	always #20 clk = ~clk;

	task automatic compare_value(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		if (got !== expected) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
			mismatch_count++;
		end
	endtask

	//////////////////////////////
	// Program generation

	// Mostly r1 to r4 so that neighbours depend on each other
	task automatic pick_reg(output logic [3:0] r);
		int pick;
		pick = $unsigned($random(seed)) % 8;
		if (pick < 6) begin
			r = 4'(1 + pick % 4);
		end else begin
			r = 4'($unsigned($random(seed)) % 16);
		end
	endtask

	task automatic gen_instr(input int idx, output logic [15:0] instr);
		int         kind;
		int         off;
		logic [3:0] rd;
		logic [3:0] rs1;
		logic [3:0] rs2;
		logic [3:0] imm;
		kind = $unsigned($random(seed)) % 20;
		pick_reg(rd);
		pick_reg(rs1);
		pick_reg(rs2);
		imm = 4'($unsigned($random(seed)) % 16);
		// Half the memory accesses use r0 as base, so addresses repeat
		if (kind >= 10 && kind <= 15 && ($unsigned($random(seed)) % 2) == 0) begin
			rs1 = 4'h0;
		end
		if (kind <= 6) begin
			instr = {4'(kind), rd, rs2, rs1};
		end else if (kind <= 9 || kind == 19) begin
			instr = {OP_ADDI, rd, imm, rs1};
		end else if (kind <= 12) begin
			instr = {OP_LW, rd, imm, rs1};
		end else if (kind <= 15) begin
			instr = {OP_SW, imm, rs2, rs1};
		end else if (kind <= 17) begin
			// Forward only and never past the final HALT
			off = 1 + $unsigned($random(seed)) % 4;
			if (idx + off > PROG_LEN) begin
				off = PROG_LEN - idx;
			end
			instr = {(kind == 16) ? OP_BEQ : OP_BNE, 4'(off), rs2, rs1};
		end else begin
			instr = {4'(4'hD + $unsigned($random(seed)) % 3), 12'h000};
		end
	endtask

	task automatic build_program();
		logic [15:0] instr;
		seed = 86;
		// Give r1 to r4 nonzero starting values
		for (int i = 0; i < 4; i++) begin
			prog[i] = {OP_ADDI, 4'(i + 1), 4'($unsigned($random(seed)) % 15 + 1), 4'h0};
		end
		for (int i = 4; i < PROG_LEN; i++) begin
			gen_instr(i, instr);
			prog[i] = instr;
		end
		prog[PROG_LEN] = {OP_HALT, 12'h000};
	endtask

	//////////////////////////////
	// Sequential reference

	task automatic write_expected(input logic [3:0] rd, input logic [15:0] value);
		if (rd != 4'h0) begin
			model_regs[rd] = value;
			exp_rd_q.push_back(rd);
			exp_data_q.push_back(value);
		end
	endtask

	task automatic run_reference();
		int          pc;
		int          next_pc;
		int          steps;
		bit          done;
		logic [15:0] instr;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] addr;
		opcode_t     op;
		logic [3:0]  f_rd;
		logic [3:0]  f_rs2;
		logic [3:0]  f_rs1;
		for (int i = 0; i < 2**REG_AW; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < 2**DMEM_AW; i++) begin
			model_mem[i] = '0;
		end
		pc    = 0;
		steps = 0;
		done  = 1'b0;
		while (!done && steps < 4 * PROG_LEN) begin
			instr   = prog[pc];
			op      = opcode_t'(instr[15:12]);
			f_rd    = instr[11:8];
			f_rs2   = instr[7:4];
			f_rs1   = instr[3:0];
			a       = model_regs[f_rs1];
			b       = model_regs[f_rs2];
			next_pc = pc + 1;
			case (op)
				OP_ADD:  write_expected(f_rd, a + b);
				OP_SUB:  write_expected(f_rd, a - b);
				OP_AND:  write_expected(f_rd, a & b);
				OP_OR:   write_expected(f_rd, a | b);
				OP_XOR:  write_expected(f_rd, a ^ b);
				OP_SLL:  write_expected(f_rd, a << b[3:0]);
				OP_SRL:  write_expected(f_rd, a >> b[3:0]);
				OP_ADDI: write_expected(f_rd, a + {12'h000, f_rs2});
				OP_LW: begin
					addr = a + {12'h000, f_rs2};
					write_expected(f_rd, model_mem[addr[DMEM_AW-1:0]]);
				end
				// Store offset lives in the rd field
				OP_SW: begin
					addr = a + {12'h000, f_rd};
					model_mem[addr[DMEM_AW-1:0]] = b;
					exp_saddr_q.push_back(addr[DMEM_AW-1:0]);
					exp_sdata_q.push_back(b);
				end
				OP_BEQ: if (a == b) next_pc = pc + int'(f_rd);
				OP_BNE: if (a != b) next_pc = pc + int'(f_rd);
				OP_HALT: done = 1'b1;
				default: ;
			endcase
			pc = next_pc;
			steps++;
		end
		if (!done) begin
			$display("Reference model did not reach HALT");
			other_errors++;
		end
	endtask

	//////////////////////////////
	// Output monitor
	always @(negedge clk) begin
		if (rst === 1'b0) begin
			if (retire_valid === 1'b1) begin
				if (halted === 1'b1) begin
					$display("Register write to r%0d retired after halt", retire_rd);
					other_errors++;
				end else if (exp_rd_q.size() == 0) begin
					$display("Unexpected register write to r%0d, none left in the model",
						retire_rd);
					other_errors++;
				end else begin
					exp_rd   = exp_rd_q.pop_front();
					exp_data = exp_data_q.pop_front();
					compare_value("retire_rd", 16'(retire_rd), 16'(exp_rd));
					compare_value("retire_data", retire_data, exp_data);
					retire_count++;
				end
			end else if (retire_valid !== 1'b0) begin
				$display("retire_valid is unknown at %0t", $time);
				other_errors++;
			end
			if (store_valid === 1'b1) begin
				if (exp_saddr_q.size() == 0) begin
					$display("Unexpected store to address 0x%h, none left in the model",
						store_addr);
					other_errors++;
				end else begin
					exp_saddr = exp_saddr_q.pop_front();
					exp_sdata = exp_sdata_q.pop_front();
					compare_value("store_addr", 16'(store_addr), 16'(exp_saddr));
					compare_value("store_data", store_data, exp_sdata);
					store_count++;
				end
			end else if (store_valid !== 1'b0) begin
				$display("store_valid is unknown at %0t", $time);
				other_errors++;
			end
		end
	end

	//////////////////////////////
	// Main sequence
	initial begin
		clk            = 1'b0;
		rst            = 1'b1;
		imem_load_en   = 1'b0;
		imem_load_addr = '0;
		imem_load_data = '0;
		mismatch_count = 0;
		other_errors   = 0;
		retire_count   = 0;
		store_count    = 0;

		build_program();
		run_reference();

		// One word per cycle while reset is high
		for (int i = 0; i <= PROG_LEN; i++) begin
			@(negedge clk);
			imem_load_en   = 1'b1;
			imem_load_addr = IMEM_AW'(i);
			imem_load_data = prog[i];
		end
		@(negedge clk);
		imem_load_en = 1'b0;

		repeat (RESET_CYCLES) begin
			@(negedge clk);
			compare_value("retire_valid", 16'(retire_valid), 16'h0000);
			compare_value("store_valid", 16'(store_valid), 16'h0000);
			compare_value("halted", 16'(halted), 16'h0000);
		end
		rst = 1'b0;

		// Nothing can reach writeback this early
		repeat (2) begin
			@(negedge clk);
			compare_value("retire_valid", 16'(retire_valid), 16'h0000);
			compare_value("store_valid", 16'(store_valid), 16'h0000);
			compare_value("halted", 16'(halted), 16'h0000);
		end

		cycles = 0;
		while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			$display("Timeout: halted did not rise within %0d cycles", HALT_TIMEOUT);
			other_errors++;
		end else begin
			if (exp_rd_q.size() != 0) begin
				$display("%0d expected register writes never retired", exp_rd_q.size());
				other_errors++;
			end
			if (exp_saddr_q.size() != 0) begin
				$display("%0d expected stores never appeared", exp_saddr_q.size());
				other_errors++;
			end
			// Quiet window, the monitor flags anything that still retires
			repeat (QUIET_CYCLES) @(negedge clk);
			compare_value("halted", 16'(halted), 16'h0001);
		end

		$display("Checks done: %0d mismatches, %0d other errors, %0d writes, %0d stores",
			mismatch_count, other_errors, retire_count, store_count);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cpu16_top.sv
`default_nettype none

module cpu16_top
	import cpu16_pkg::*;
#(
	parameter int IMEM_AW = 8,
	parameter int DMEM_AW = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               imem_load_en,
	input  logic [IMEM_AW-1:0] imem_load_addr,
	input  logic [XLEN-1:0]    imem_load_data,
	output logic               retire_valid,
	output logic [REG_AW-1:0]  retire_rd,
	output logic [XLEN-1:0]    retire_data,
	output logic               store_valid,
	output logic [DMEM_AW-1:0] store_addr,
	output logic [XLEN-1:0]    store_data,
	output logic               halted
);
	// Fetch/decode
	logic [XLEN-1:0]   id_instr;
	logic [XLEN-1:0]   id_pc;
	logic [REG_AW-1:0] id_rs1;
	logic [REG_AW-1:0] id_rs2;
	logic              id_uses_rs1;
	logic              id_uses_rs2;
	logic              id_is_branch;
	logic              branch_taken;
	logic [XLEN-1:0]   branch_target;
	logic              halt_seen;
	// Hazard control
	logic              stall;
	logic              flush;
	fwd_sel_t          fwd_a;
	fwd_sel_t          fwd_b;
	// Decode/execute register
	logic [XLEN-1:0]   ex_a;
	logic [XLEN-1:0]   ex_b;
	logic [XLEN-1:0]   ex_imm;
	logic [REG_AW-1:0] ex_rs1;
	logic [REG_AW-1:0] ex_rs2;
	logic [REG_AW-1:0] ex_rd;
	alu_op_t           ex_alu_op;
	logic              ex_use_imm;
	logic              ex_reg_we;
	logic              ex_mem_we;
	logic              ex_is_load;
	logic              ex_halt;
	// Execute/memory register
	logic [XLEN-1:0]   mem_alu;
	logic [XLEN-1:0]   mem_store_data;
	logic [REG_AW-1:0] mem_rd;
	logic              mem_reg_we;
	logic              mem_mem_we;
	logic              mem_is_load;
	logic              mem_halt;
	// Writeback
	logic              wb_reg_we;
	logic [REG_AW-1:0] wb_rd;
	logic [XLEN-1:0]   wb_data;

	//////////////////////////////
	// Front end
	fetch_stage #(
		.IMEM_AW(IMEM_AW)
	) fetch_stage_inst (
		.clk(clk),
		.rst(rst),
		.load_en(imem_load_en),
		.load_addr(imem_load_addr),
		.load_data(imem_load_data),
		.stall(stall),
		.flush(flush),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.halt_seen(halt_seen),
		.id_instr(id_instr),
		.id_pc(id_pc)
	);

	decode_stage decode_stage_inst (
		.clk(clk),
		.rst(rst),
		.instr(id_instr),
		.pc(id_pc),
		.stall(stall),
		.wb_reg_we(wb_reg_we),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.rs1(id_rs1),
		.rs2(id_rs2),
		.uses_rs1(id_uses_rs1),
		.uses_rs2(id_uses_rs2),
		.is_branch(id_is_branch),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.halt_seen(halt_seen),
		.ex_a(ex_a),
		.ex_b(ex_b),
		.ex_imm(ex_imm),
		.ex_rs1(ex_rs1),
		.ex_rs2(ex_rs2),
		.ex_rd(ex_rd),
		.ex_alu_op(ex_alu_op),
		.ex_use_imm(ex_use_imm),
		.ex_reg_we(ex_reg_we),
		.ex_mem_we(ex_mem_we),
		.ex_is_load(ex_is_load),
		.ex_halt(ex_halt)
	);

	hazard_unit hazard_unit_inst (
		.id_rs1(id_rs1),
		.id_rs2(id_rs2),
		.id_uses_rs1(id_uses_rs1),
		.id_uses_rs2(id_uses_rs2),
		.id_is_branch(id_is_branch),
		.id_branch_taken(branch_taken),
		.ex_rd(ex_rd),
		.ex_reg_we(ex_reg_we),
		.ex_is_load(ex_is_load),
		.ex_rs1(ex_rs1),
		.ex_rs2(ex_rs2),
		.mem_rd(mem_rd),
		.mem_reg_we(mem_reg_we),
		.mem_is_load(mem_is_load),
		.wb_rd(wb_rd),
		.wb_reg_we(wb_reg_we),
		.stall(stall),
		.flush(flush),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	//////////////////////////////
	// Back end
	execute_stage execute_stage_inst (
		.clk(clk),
		.rst(rst),
		.ex_a(ex_a),
		.ex_b(ex_b),
		.ex_imm(ex_imm),
		.ex_rd(ex_rd),
		.ex_alu_op(ex_alu_op),
		.ex_use_imm(ex_use_imm),
		.ex_reg_we(ex_reg_we),
		.ex_mem_we(ex_mem_we),
		.ex_is_load(ex_is_load),
		.ex_halt(ex_halt),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.mem_fwd_value(mem_alu),
		.wb_fwd_value(wb_data),
		.mem_alu(mem_alu),
		.mem_store_data(mem_store_data),
		.mem_rd(mem_rd),
		.mem_reg_we(mem_reg_we),
		.mem_mem_we(mem_mem_we),
		.mem_is_load(mem_is_load),
		.mem_halt(mem_halt)
	);

	mem_wb_stage #(
		.DMEM_AW(DMEM_AW)
	) mem_wb_stage_inst (
		.clk(clk),
		.rst(rst),
		.mem_alu(mem_alu),
		.mem_store_data(mem_store_data),
		.mem_rd(mem_rd),
		.mem_reg_we(mem_reg_we),
		.mem_mem_we(mem_mem_we),
		.mem_is_load(mem_is_load),
		.mem_halt(mem_halt),
		.wb_reg_we(wb_reg_we),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_data(retire_data),
		.store_valid(store_valid),
		.store_addr(store_addr),
		.store_data(store_data),
		.halted(halted)
	);

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

module decode_stage
	import cpu16_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [XLEN-1:0]   instr,
	input  logic [XLEN-1:0]   pc,
	input  logic              stall,
	input  logic              wb_reg_we,
	input  logic [REG_AW-1:0] wb_rd,
	input  logic [XLEN-1:0]   wb_data,
	output logic [REG_AW-1:0] rs1,
	output logic [REG_AW-1:0] rs2,
	output logic              uses_rs1,
	output logic              uses_rs2,
	output logic              is_branch,
	output logic              branch_taken,
	output logic [XLEN-1:0]   branch_target,
	output logic              halt_seen,
	output logic [XLEN-1:0]   ex_a,
	output logic [XLEN-1:0]   ex_b,
	output logic [XLEN-1:0]   ex_imm,
	output logic [REG_AW-1:0] ex_rs1,
	output logic [REG_AW-1:0] ex_rs2,
	output logic [REG_AW-1:0] ex_rd,
	output alu_op_t           ex_alu_op,
	output logic              ex_use_imm,
	output logic              ex_reg_we,
	output logic              ex_mem_we,
	output logic              ex_is_load,
	output logic              ex_halt
);
	opcode_t           op;
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   rd1;
	logic [XLEN-1:0]   rd2;
	logic [XLEN-1:0]   imm;
	alu_op_t           alu_op;
	logic              use_imm;
	logic              writes_rd;
	logic              mem_we;
	logic              is_load;

	assign op  = opcode_t'(instr[15:12]);
	assign rd  = instr[11:8];
	assign rs2 = instr[7:4];
	assign rs1 = instr[3:0];

	reg_file reg_file_inst (
		.clk(clk),
		.rst(rst),
		.ra1(rs1),
		.ra2(rs2),
		.rd1(rd1),
		.rd2(rd2),
		.we(wb_reg_we),
		.wa(wb_rd),
		.wd(wb_data)
	);

	//////////////////////////////
	// Control decode
	always_comb begin
		uses_rs1  = 1'b0;
		uses_rs2  = 1'b0;
		is_branch = 1'b0;
		halt_seen = 1'b0;
		alu_op    = ALU_ADD;
		use_imm   = 1'b0;
		writes_rd = 1'b0;
		mem_we    = 1'b0;
		is_load   = 1'b0;
		imm       = '0;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL: begin
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
				alu_op    = alu_op_t'(instr[14:12]);
				writes_rd = 1'b1;
			end
			OP_ADDI, OP_LW: begin
				uses_rs1  = 1'b1;
				use_imm   = 1'b1;
				imm       = XLEN'(instr[7:4]);
				writes_rd = 1'b1;
				is_load   = (op == OP_LW);
			end
			// Offset sits in the rd field, data comes from rs2
			OP_SW: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				use_imm  = 1'b1;
				imm      = XLEN'(instr[11:8]);
				mem_we   = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
				is_branch = 1'b1;
			end
			OP_HALT: halt_seen = 1'b1;
			default: ;
		endcase
	end

	// Branch resolution against the branch's own PC
	assign branch_target = pc + XLEN'(instr[11:8]);
	assign branch_taken  = !stall && is_branch && ((op == OP_BEQ) == (rd1 == rd2));

	//////////////////////////////
	// Decode/execute register
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			ex_reg_we  <= 1'b0;
			ex_mem_we  <= 1'b0;
			ex_is_load <= 1'b0;
			ex_halt    <= 1'b0;
		end else begin
			ex_reg_we  <= writes_rd && (rd != '0);
			ex_mem_we  <= mem_we;
			ex_is_load <= is_load;
			ex_halt    <= halt_seen;
		end
	end

	always_ff @(posedge clk) begin
		ex_a       <= rd1;
		ex_b       <= rd2;
		ex_imm     <= imm;
		ex_rs1     <= rs1;
		ex_rs2     <= rs2;
		ex_rd      <= rd;
		ex_alu_op  <= alu_op;
		ex_use_imm <= use_imm;
	end

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage
	import cpu16_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [XLEN-1:0]   ex_a,
	input  logic [XLEN-1:0]   ex_b,
	input  logic [XLEN-1:0]   ex_imm,
	input  logic [REG_AW-1:0] ex_rd,
	input  alu_op_t           ex_alu_op,
	input  logic              ex_use_imm,
	input  logic              ex_reg_we,
	input  logic              ex_mem_we,
	input  logic              ex_is_load,
	input  logic              ex_halt,
	input  fwd_sel_t          fwd_a,
	input  fwd_sel_t          fwd_b,
	input  logic [XLEN-1:0]   mem_fwd_value,
	input  logic [XLEN-1:0]   wb_fwd_value,
	output logic [XLEN-1:0]   mem_alu,
	output logic [XLEN-1:0]   mem_store_data,
	output logic [REG_AW-1:0] mem_rd,
	output logic              mem_reg_we,
	output logic              mem_mem_we,
	output logic              mem_is_load,
	output logic              mem_halt
);
	logic [XLEN-1:0] src_a;
	logic [XLEN-1:0] src_b;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_y;

	function automatic logic [XLEN-1:0] pick(
		input fwd_sel_t        sel,
		input logic [XLEN-1:0] reg_val,
		input logic [XLEN-1:0] mem_val,
		input logic [XLEN-1:0] wb_val
	);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	//////////////////////////////
	// Operand select
	assign src_a = pick(fwd_a, ex_a, mem_fwd_value, wb_fwd_value);
	assign src_b = pick(fwd_b, ex_b, mem_fwd_value, wb_fwd_value);
	// Forwarded B stays the store data even when imm feeds the ALU
	assign alu_b = ex_use_imm ? ex_imm : src_b;

	// ALU, shift amount from low 4 bits of B
	always_comb begin
		case (ex_alu_op)
			ALU_SUB: alu_y = src_a - alu_b;
			ALU_AND: alu_y = src_a & alu_b;
			ALU_OR:  alu_y = src_a | alu_b;
			ALU_XOR: alu_y = src_a ^ alu_b;
			ALU_SLL: alu_y = src_a << alu_b[3:0];
			ALU_SRL: alu_y = src_a >> alu_b[3:0];
			default: alu_y = src_a + alu_b;
		endcase
	end

	//////////////////////////////
	// Execute/memory register
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_reg_we  <= 1'b0;
			mem_mem_we  <= 1'b0;
			mem_is_load <= 1'b0;
			mem_halt    <= 1'b0;
		end else begin
			mem_reg_we  <= ex_reg_we;
			mem_mem_we  <= ex_mem_we;
			mem_is_load <= ex_is_load;
			mem_halt    <= ex_halt;
		end
	end

	always_ff @(posedge clk) begin
		mem_alu        <= alu_y;
		mem_store_data <= src_b;
		mem_rd         <= ex_rd;
	end

endmodule

`default_nettype wire

//--- fetch_stage.sv
`default_nettype none

module fetch_stage
	import cpu16_pkg::*;
#(
	parameter int IMEM_AW = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               load_en,
	input  logic [IMEM_AW-1:0] load_addr,
	input  logic [XLEN-1:0]    load_data,
	input  logic               stall,
	input  logic               flush,
	input  logic               branch_taken,
	input  logic [XLEN-1:0]    branch_target,
	input  logic               halt_seen,
	output logic [XLEN-1:0]    id_instr,
	output logic [XLEN-1:0]    id_pc
);
	logic [XLEN-1:0] imem [2**IMEM_AW];
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] if_instr;
	logic            halt_q;
	logic            pc_hold;
	logic            kill;

	// Asynchronous read, only low PC bits address the array
	assign if_instr = imem[pc[IMEM_AW-1:0]];

	// PC stops for good once HALT has been decoded
	assign pc_hold = stall || halt_seen || halt_q;
	assign kill    = flush || halt_seen || halt_q;

	// Program load port
	always_ff @(posedge clk) begin
		if (load_en) begin
			imem[load_addr] <= load_data;
		end
	end

	//////////////////////////////
	// PC register
	always_ff @(posedge clk) begin
		if (rst) begin
			pc     <= '0;
			halt_q <= 1'b0;
		end else begin
			if (halt_seen) begin
				halt_q <= 1'b1;
			end
			if (!pc_hold) begin
				pc <= branch_taken ? branch_target : pc + XLEN'(1);
			end
		end
	end

	//////////////////////////////
	// Fetch/decode register
	always_ff @(posedge clk) begin
		if (rst) begin
			id_instr <= NOP_INSTR;
			id_pc    <= '0;
		end else if (!stall) begin
			id_instr <= kill ? NOP_INSTR : if_instr;
			id_pc    <= pc;
		end
	end

	// A stalled cycle must leave the fetch address alone
	assert property (@(posedge clk) disable iff (rst) stall |=> $stable(pc));

endmodule

`default_nettype wire

//--- hazard_unit.sv
`default_nettype none

module hazard_unit
	import cpu16_pkg::*;
(
	input  logic [REG_AW-1:0] id_rs1,
	input  logic [REG_AW-1:0] id_rs2,
	input  logic              id_uses_rs1,
	input  logic              id_uses_rs2,
	input  logic              id_is_branch,
	input  logic              id_branch_taken,
	input  logic [REG_AW-1:0] ex_rd,
	input  logic              ex_reg_we,
	input  logic              ex_is_load,
	input  logic [REG_AW-1:0] ex_rs1,
	input  logic [REG_AW-1:0] ex_rs2,
	input  logic [REG_AW-1:0] mem_rd,
	input  logic              mem_reg_we,
	input  logic              mem_is_load,
	input  logic [REG_AW-1:0] wb_rd,
	input  logic              wb_reg_we,
	output logic              stall,
	output logic              flush,
	output fwd_sel_t          fwd_a,
	output fwd_sel_t          fwd_b
);
	logic id_reads_ex;
	logic id_reads_mem;
	logic load_use;
	logic branch_wait;

	//////////////////////////////
	// Stall and flush
	// Decode source written by the instruction one or two stages ahead
	assign id_reads_ex  = ex_reg_we &&
		((id_uses_rs1 && id_rs1 == ex_rd) || (id_uses_rs2 && id_rs2 == ex_rd));
	assign id_reads_mem = mem_reg_we &&
		((id_uses_rs1 && id_rs1 == mem_rd) || (id_uses_rs2 && id_rs2 == mem_rd));

	// Load data exists only in writeback, one bubble is enough
	assign load_use = ex_is_load && id_reads_ex;

	// Branch compares register file values, so hold until writeback
	assign branch_wait = id_is_branch && (id_reads_ex || id_reads_mem);

	assign stall = load_use || branch_wait;
	assign flush = id_branch_taken;

	//////////////////////////////
	// Forwarding select
	// A load in memory holds only its address, nothing to forward yet
	always_comb begin
		if (mem_reg_we && !mem_is_load && mem_rd == ex_rs1) begin
			fwd_a = FWD_MEM;
		end else if (wb_reg_we && wb_rd == ex_rs1) begin
			fwd_a = FWD_WB;
		end else begin
			fwd_a = FWD_REG;
		end
		if (mem_reg_we && !mem_is_load && mem_rd == ex_rs2) begin
			fwd_b = FWD_MEM;
		end else if (wb_reg_we && wb_rd == ex_rs2) begin
			fwd_b = FWD_WB;
		end else begin
			fwd_b = FWD_REG;
		end
	end

	// A stalled branch must never redirect fetch
	always_comb begin
		assert (!(stall && flush));
	end

endmodule

`default_nettype wire

//--- mem_wb_stage.sv
`default_nettype none

module mem_wb_stage
	import cpu16_pkg::*;
#(
	parameter int DMEM_AW = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  logic [XLEN-1:0]    mem_alu,
	input  logic [XLEN-1:0]    mem_store_data,
	input  logic [REG_AW-1:0]  mem_rd,
	input  logic               mem_reg_we,
	input  logic               mem_mem_we,
	input  logic               mem_is_load,
	input  logic               mem_halt,
	output logic               wb_reg_we,
	output logic [REG_AW-1:0]  wb_rd,
	output logic [XLEN-1:0]    wb_data,
	output logic               retire_valid,
	output logic [REG_AW-1:0]  retire_rd,
	output logic [XLEN-1:0]    retire_data,
	output logic               store_valid,
	output logic [DMEM_AW-1:0] store_addr,
	output logic [XLEN-1:0]    store_data,
	output logic               halted
);
	logic [XLEN-1:0]    dmem [2**DMEM_AW];
	logic [DMEM_AW-1:0] addr;
	logic [XLEN-1:0]    load_data;
	logic [XLEN-1:0]    wb_alu;
	logic [XLEN-1:0]    wb_load;
	wb_sel_t            wb_sel;

	assign addr      = mem_alu[DMEM_AW-1:0];
	assign load_data = dmem[addr];

	//////////////////////////////
	// Data memory
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**DMEM_AW; i++) begin
				dmem[i] <= '0;
			end
		end else if (mem_mem_we) begin
			dmem[addr] <= mem_store_data;
		end
	end

	//////////////////////////////
	// Memory/writeback register
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_reg_we   <= 1'b0;
			store_valid <= 1'b0;
			halted      <= 1'b0;
		end else begin
			wb_reg_we   <= mem_reg_we;
			store_valid <= mem_mem_we;
			// Sticky until reset
			halted      <= halted || mem_halt;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd      <= mem_rd;
		wb_alu     <= mem_alu;
		wb_load    <= load_data;
		wb_sel     <= mem_is_load ? WB_LOAD : WB_ALU;
		store_addr <= addr;
		store_data <= mem_store_data;
	end

	assign wb_data = (wb_sel == WB_LOAD) ? wb_load : wb_alu;

	// rd zero already filtered in decode
	assign retire_valid = wb_reg_we;
	assign retire_rd    = wb_rd;
	assign retire_data  = wb_data;

	assert property (@(posedge clk) disable iff (rst) mem_mem_we |-> !mem_reg_we);

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file
	import cpu16_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [REG_AW-1:0] ra1,
	input  logic [REG_AW-1:0] ra2,
	output logic [XLEN-1:0]   rd1,
	output logic [XLEN-1:0]   rd2,
	input  logic              we,
	input  logic [REG_AW-1:0] wa,
	input  logic [XLEN-1:0]   wd
);
	logic [XLEN-1:0] regs [2**REG_AW];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Writeback value goes straight through in the same cycle
	assign rd1 = (we && wa != '0 && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (we && wa != '0 && wa == ra2) ? wd : regs[ra2];

	assert property (@(posedge clk) disable iff (rst) (ra1 == '0) |-> (rd1 == '0));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the cpu16 testbench with Verilator, run it, then scan the log

verilator --binary --timing --assert -j 0 --top-module cpu16_tb \
	-f cpu16.f -o cpu16_sim > build.log 2>&1 \
	&& ./obj_dir/cpu16_sim > sim.log 2>&1 \
	&& cat sim.log \
	&& ! grep -q "TEST FAILED" sim.log \
	&& echo "Simulation passed" \
	|| { cat build.log sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }
